// ==== rtl/mem_pkg.sv ====
package mem_pkg;

    // Bus-level sizes, fixed at one 32-bit word
    parameter int ADDR_W         = 32;
    parameter int DATA_W         = 32;
    parameter int BYTES_PER_WORD = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;   // Byte address
    typedef logic [DATA_W-1:0] word_t;   // Data word

endpackage

// ==== rtl/dcache_pkg.sv ====
package dcache_pkg;

    // Defaults for the cache and backing RAM, both powers of two
    parameter int DEFAULT_LINES     = 8;
    parameter int DEFAULT_RAM_WORDS = 32768;

    // Controller state
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        FILL = 2'd1
    } state_e;

endpackage

// ==== rtl/mem_if.sv ====
`timescale 1ns/1ps

interface mem_if ();
    import mem_pkg::*;

    logic  re;      // Read strobe, data one cycle later
    logic  we;      // Write strobe, takes effect at the edge
    addr_t addr;
    word_t wdata;
    word_t rdata;

    // Cache side drives strobes, address and write data
    modport cache (
        output re,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport ram (
        input  re,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// ==== rtl/byte_ram.sv ====
`timescale 1ns/1ps

module byte_ram #(
    parameter int unsigned RAM_WORDS = dcache_pkg::DEFAULT_RAM_WORDS
) (
    input logic clk_i,
    mem_if.ram  mem
);
    import mem_pkg::*;

    localparam int unsigned RAM_BYTES = RAM_WORDS * BYTES_PER_WORD;
    localparam int unsigned WIDX_W    = $clog2(RAM_WORDS);

    logic [7:0] ram_q [RAM_BYTES];

    logic [WIDX_W-1:0] word_idx;
    word_t             rd_word;
    logic [7:0]        wr_byte [BYTES_PER_WORD];

    // Only the word-index bits inside the RAM are decoded
    assign word_idx = mem.addr[WIDX_W+1:2];

    // Big-endian layout, byte 0 holds the MSB
    always_comb begin
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            wr_byte[b] = mem.wdata[DATA_W-1-8*b -: 8];
        end
    end

    always_comb begin
        rd_word = '0;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            rd_word[DATA_W-1-8*b -: 8] = ram_q[{word_idx, 2'(b)}];
        end
    end

    // Write lands at the edge
    always_ff @(posedge clk_i) begin
        if (mem.we) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                ram_q[{word_idx, 2'(b)}] <= wr_byte[b];
            end
        end
    end

    // Registered read, one cycle from re
    always_ff @(posedge clk_i) begin
        if (mem.re) begin
            mem.rdata <= rd_word;
        end
    end

endmodule

// ==== rtl/dcache.sv ====
`timescale 1ns/1ps

module dcache #(
    parameter int unsigned LINES = dcache_pkg::DEFAULT_LINES
) (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           req_i,     // Request strobe, ignored while busy
    input  logic           we_i,      // 1 = write, 0 = read
    input  mem_pkg::addr_t addr_i,
    input  mem_pkg::word_t wdata_i,
    output logic           busy_o,
    output logic           valid_o,   // Read data valid
    output logic           hit_o,
    output mem_pkg::word_t rdata_o,
    mem_if.cache           mem
);
    import mem_pkg::*;
    import dcache_pkg::*;

    localparam int unsigned IDX_W = $clog2(LINES);
    localparam int unsigned TAG_W = ADDR_W - IDX_W - 2;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    // Line storage
    logic [LINES-1:0] valid_q;
    tag_t             tag_q  [LINES];
    word_t            data_q [LINES];

    state_e state_q;
    idx_t   fill_idx_q;   // Line waiting for the RAM word
    tag_t   fill_tag_q;

    idx_t req_idx;
    tag_t req_tag;
    logic accept;
    logic lookup_hit;
    logic rd_miss;
    logic wr_req;

    // Address split, low two bits ignored
    assign req_idx = addr_i[IDX_W+1:2];
    assign req_tag = addr_i[ADDR_W-1:IDX_W+2];

    assign lookup_hit = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

    assign busy_o  = (state_q == FILL);
    assign accept  = req_i && !busy_o;
    assign wr_req  = accept && we_i;
    assign rd_miss = accept && !we_i && !lookup_hit;

    // Writes go through to RAM; a read miss fetches in the request cycle
    assign mem.re    = rd_miss;
    assign mem.we    = wr_req;
    assign mem.addr  = addr_i;
    assign mem.wdata = wdata_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            valid_o <= 1'b0;
            hit_o   <= 1'b0;
            rdata_o <= '0;
            valid_q <= '0;   // All lines invalid
        end else begin
            valid_o <= 1'b0;
            hit_o   <= 1'b0;
            unique case (state_q)
                IDLE: begin
                    if (accept && !we_i) begin
                        if (lookup_hit) begin
                            valid_o <= 1'b1;
                            hit_o   <= 1'b1;
                            rdata_o <= data_q[req_idx];
                        end else begin
                            state_q <= FILL;
                        end
                    end
                end
                FILL: begin
                    // RAM word arrives this cycle
                    valid_o             <= 1'b1;
                    rdata_o             <= mem.rdata;
                    valid_q[fill_idx_q] <= 1'b1;
                    state_q             <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk_i) begin
        if (rd_miss) begin
            fill_idx_q <= req_idx;
            fill_tag_q <= req_tag;
        end
        if (state_q == FILL) begin
            tag_q[fill_idx_q]  <= fill_tag_q;
            data_q[fill_idx_q] <= mem.rdata;
        end else if (wr_req && lookup_hit) begin
            data_q[req_idx] <= wdata_i;   // No allocate on write miss
        end
    end

endmodule

// ==== rtl/data_memory_top.sv ====
`timescale 1ns/1ps

module data_memory_top #(
    parameter int unsigned LINES     = dcache_pkg::DEFAULT_LINES,
    parameter int unsigned RAM_WORDS = dcache_pkg::DEFAULT_RAM_WORDS
) (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           req_i,
    input  logic           we_i,
    input  mem_pkg::addr_t addr_i,
    input  mem_pkg::word_t wdata_i,
    output logic           busy_o,
    output logic           valid_o,
    output logic           hit_o,
    output mem_pkg::word_t rdata_o
);

    // Cache to RAM port
    mem_if u_mem_bus ();

    dcache #(
        .LINES   (LINES)
    ) u_dcache (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (req_i),
        .we_i    (we_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .busy_o  (busy_o),
        .valid_o (valid_o),
        .hit_o   (hit_o),
        .rdata_o (rdata_o),
        .mem     (u_mem_bus.cache)
    );

    // Backing store, no reset
    byte_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .clk_i     (clk_i),
        .mem       (u_mem_bus.ram)
    );

endmodule

// ==== tests/dcache_chk.sv ====
`timescale 1ns/1ps

module dcache_chk (
    input logic               clk_i,
    input logic               rst_n_i,
    input logic               valid_i,
    input logic               hit_i,
    input dcache_pkg::state_e state_i,
    input logic               mem_re_i,
    input logic               mem_we_i
);
    import dcache_pkg::*;

    int unsigned fail_cnt = 0;   // Read back by the testbench at the end

    hit_implies_valid: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) hit_i |-> valid_i
    ) else begin
        $error("hit_o high without valid_o");
        fail_cnt++;
    end

    // A fill always ends in a missed read response
    fill_then_miss_valid: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) (state_i == FILL) |=> (valid_i && !hit_i)
    ) else begin
        $error("FILL not followed by valid_o with hit_o low");
        fail_cnt++;
    end

    no_write_in_fill: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) (state_i == FILL) |-> !mem_we_i
    ) else begin
        $error("RAM write during FILL");
        fail_cnt++;
    end

    re_we_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !(mem_re_i && mem_we_i)
    ) else begin
        $error("re and we high together on the RAM port");
        fail_cnt++;
    end

endmodule

// RAM strobes as they appear on the cache's bus port
bind dcache dcache_chk u_dcache_chk (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .valid_i  (valid_o),
    .hit_i    (hit_o),
    .state_i  (state_q),
    .mem_re_i (mem.re),
    .mem_we_i (mem.we)
);

// ==== tests/dmem_monitor.sv ====
`timescale 1ns/1ps

module dmem_monitor (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           exp_stb_i,    // One expectation per read issued
    input  mem_pkg::word_t exp_data_i,
    input  logic           exp_hit_i,
    input  logic           busy_i,
    input  logic           valid_i,
    input  logic           hit_i,
    input  mem_pkg::word_t rdata_i,
    input  logic           drain_i,      // End of stimulus
    output logic           done_o,
    output int             err_cnt_o,
    output int             chk_cnt_o
);
    import mem_pkg::*;

    word_t exp_data_q [$];
    logic  exp_hit_q  [$];
    logic  busy_exp_q;   // Busy level expected in the current cycle

    always @(posedge clk_i) begin : compare_blk
        word_t exp_data;
        logic  exp_hit;

        if (!rst_n_i) begin
            exp_data_q.delete();
            exp_hit_q.delete();
            err_cnt_o = 0;
            chk_cnt_o = 0;
            done_o     <= 1'b0;
            busy_exp_q <= 1'b0;
        end else begin
            if (busy_i !== busy_exp_q) begin
                $display("ERROR at %0t: busy_o = %0b, expected %0b",
                         $time, busy_i, busy_exp_q);
                err_cnt_o++;
            end
            // Only a read miss holds the cache for the next cycle
            busy_exp_q <= exp_stb_i && !exp_hit_i;

            // Queue first so a response never overtakes its own expectation
            if (exp_stb_i) begin
                exp_data_q.push_back(exp_data_i);
                exp_hit_q.push_back(exp_hit_i);
            end
            if (valid_i) begin
                if (exp_data_q.size() == 0) begin
                    $display("Read response at %0t arrived with no read outstanding", $time);
                    err_cnt_o++;
                end else begin
                    exp_data = exp_data_q.pop_front();
                    exp_hit  = exp_hit_q.pop_front();
                    chk_cnt_o++;
                    if (rdata_i !== exp_data) begin
                        $display("ERROR at %0t: rdata_o = 0x%08h, expected 0x%08h",
                                 $time, rdata_i, exp_data);
                        err_cnt_o++;
                    end
                    if (hit_i !== exp_hit) begin
                        $display("ERROR at %0t: hit_o = %0b, expected %0b",
                                 $time, hit_i, exp_hit);
                        err_cnt_o++;
                    end
                end
            end
            if (drain_i && !done_o) begin
                if (exp_data_q.size() != 0) begin
                    $display("%0d read responses never arrived", exp_data_q.size());
                    err_cnt_o++;
                end
                done_o <= 1'b1;
            end
        end
    end

endmodule

// ==== tests/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
    import mem_pkg::*;

    localparam int LINES          = 8;
    localparam int RAM_WORDS      = 32768;
    localparam int N_ENTRIES      = 19;
    localparam int TIMEOUT_CYCLES = N_ENTRIES * 4 + 20;

    typedef struct packed {
        logic  wr;
        addr_t addr;
        word_t wdata;
        word_t exp_data;
        logic  exp_hit;
    } entry_t;

    logic  clk;
    logic  rst_n;
    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
    logic  busy;
    logic  valid;
    logic  hit;
    word_t rdata;

    logic  exp_stb;
    word_t exp_data;
    logic  exp_hit;
    logic  drain;
    logic  done;
    int    err_cnt;
    int    chk_cnt;

    entry_t stim [N_ENTRIES];

    data_memory_top #(
        .LINES     (LINES),
        .RAM_WORDS (RAM_WORDS)
    ) u_dut (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .req_i     (req),
        .we_i      (we),
        .addr_i    (addr),
        .wdata_i   (wdata),
        .busy_o    (busy),
        .valid_o   (valid),
        .hit_o     (hit),
        .rdata_o   (rdata)
    );

    dmem_monitor u_mon (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .exp_stb_i  (exp_stb),
        .exp_data_i (exp_data),
        .exp_hit_i  (exp_hit),
        .busy_i     (busy),
        .valid_i    (valid),
        .hit_i      (hit),
        .rdata_i    (rdata),
        .drain_i    (drain),
        .done_o     (done),
        .err_cnt_o  (err_cnt),
        .chk_cnt_o  (chk_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic entry_t write_op(input addr_t a, input word_t d);
        entry_t e;
        e       = '0;
        e.wr    = 1'b1;
        e.addr  = a;
        e.wdata = d;
        return e;
    endfunction

    function automatic entry_t read_op(input addr_t a, input word_t d, input logic h);
        entry_t e;
        e          = '0;
        e.addr     = a;
        e.exp_data = d;
        e.exp_hit  = h;
        return e;
    endfunction

    // Issue one entry once the cache is free, then wait out a read
    task automatic apply_entry(input entry_t e);
        @(posedge clk);
        while (busy) @(posedge clk);
        req   <= 1'b1;
        we    <= e.wr;
        addr  <= e.addr;
        wdata <= e.wdata;
        if (!e.wr) begin
            exp_stb  <= 1'b1;
            exp_data <= e.exp_data;
            exp_hit  <= e.exp_hit;
        end
        @(posedge clk);
        req     <= 1'b0;
        we      <= 1'b0;
        exp_stb <= 1'b0;
        if (!e.wr) begin
            do @(posedge clk); while (!valid);
        end
    endtask

    initial begin : main_blk
        int assert_fails;

        rst_n    = 1'b0;
        req      = 1'b0;
        we       = 1'b0;
        addr     = '0;
        wdata    = '0;
        exp_stb  = 1'b0;
        exp_data = '0;
        exp_hit  = 1'b0;
        drain    = 1'b0;

        // Lines 0x100, 0x200 and 0x220 all map to index 0
        stim[0]  = write_op(32'h0000_0100, 32'hdead_beef);
        stim[1]  = read_op(32'h0000_0100, 32'hdead_beef, 1'b0);
        stim[2]  = read_op(32'h0000_0100, 32'hdead_beef, 1'b1);
        stim[3]  = write_op(32'h0000_0200, 32'h0bad_f00d);
        stim[4]  = write_op(32'h0000_0220, 32'hcafe_f00d);
        stim[5]  = read_op(32'h0000_0200, 32'h0bad_f00d, 1'b0);
        stim[6]  = read_op(32'h0000_0220, 32'hcafe_f00d, 1'b0);
        stim[7]  = read_op(32'h0000_0200, 32'h0bad_f00d, 1'b0);
        stim[8]  = write_op(32'h0000_0200, 32'h5555_aaaa);   // Cached, line updates
        stim[9]  = read_op(32'h0000_0200, 32'h5555_aaaa, 1'b1);
        stim[10] = write_op(32'h0000_0344, 32'h1357_9bdf);   // Uncached, no allocate
        stim[11] = read_op(32'h0000_0344, 32'h1357_9bdf, 1'b0);
        stim[12] = read_op(32'h0000_0345, 32'h1357_9bdf, 1'b1);
        stim[13] = read_op(32'h0000_0346, 32'h1357_9bdf, 1'b1);
        stim[14] = read_op(32'h0000_0347, 32'h1357_9bdf, 1'b1);
        stim[15] = write_op(32'h0000_0408, 32'h0246_8ace);
        stim[16] = read_op(32'h0000_040b, 32'h0246_8ace, 1'b0);
        stim[17] = read_op(32'h0000_0409, 32'h0246_8ace, 1'b1);
        stim[18] = read_op(32'h0000_0100, 32'hdead_beef, 1'b0);   // Evicted earlier

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < N_ENTRIES; i++) begin
            apply_entry(stim[i]);
        end

        @(posedge clk);
        drain <= 1'b1;
        do @(posedge clk); while (!done);

        assert_fails = u_dut.u_dcache.u_dcache_chk.fail_cnt;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 chk_cnt, err_cnt, assert_fails);
        if (err_cnt == 0 && assert_fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog, sized from the stimulus length
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== build.f ====
rtl/mem_pkg.sv
rtl/dcache_pkg.sv
rtl/mem_if.sv
rtl/byte_ram.sv
rtl/dcache.sv
rtl/data_memory_top.sv
tests/dcache_chk.sv
tests/dmem_monitor.sv
tests/tb_top.sv

// ==== Makefile ====
# Verilator build and run for the data-memory subsystem

VERILATOR   ?= verilator
TOP         ?= tb_top
FILELIST    ?= build.f
OBJ_DIR     ?= obj_dir
BIN         ?= $(OBJ_DIR)/V$(TOP)
LOG         ?= sim.log
ERROR_LIMIT ?= 1000
VFLAGS      ?= --binary --timing --assert -j 0
PASS_TEXT   ?= PASS: all tests

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	$(BIN) +verilator+error+limit+$(ERROR_LIMIT) | tee $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
